// File: design/mdu_pkg.sv
package mdu_pkg;

  localparam int XLEN = 32;

  // Encoding follows funct3 of the M extension
  typedef enum logic [2:0] {
    OP_MUL    = 3'd0,
    OP_MULH   = 3'd1,
    OP_MULHSU = 3'd2,
    OP_MULHU  = 3'd3,
    OP_DIV    = 3'd4,
    OP_DIVU   = 3'd5,
    OP_REM    = 3'd6,
    OP_REMU   = 3'd7
  } mdu_op_t;

  typedef struct packed {
    logic is_div;   // Route to divider
    logic a_signed;
    logic b_signed;
    logic sel_high; // Upper product half
    logic sel_rem;  // Remainder instead of quotient
  } mdu_ctrl_t;

  function automatic mdu_ctrl_t decode_op(input mdu_op_t op);
    mdu_ctrl_t ctrl;
    ctrl = '0;
    case (op)
      OP_MUL:    ctrl = '{is_div: 1'b0, a_signed: 1'b0, b_signed: 1'b0, sel_high: 1'b0, sel_rem: 1'b0};
      OP_MULH:   ctrl = '{is_div: 1'b0, a_signed: 1'b1, b_signed: 1'b1, sel_high: 1'b1, sel_rem: 1'b0};
      OP_MULHSU: ctrl = '{is_div: 1'b0, a_signed: 1'b1, b_signed: 1'b0, sel_high: 1'b1, sel_rem: 1'b0};
      OP_MULHU:  ctrl = '{is_div: 1'b0, a_signed: 1'b0, b_signed: 1'b0, sel_high: 1'b1, sel_rem: 1'b0};
      OP_DIV:    ctrl = '{is_div: 1'b1, a_signed: 1'b1, b_signed: 1'b1, sel_high: 1'b0, sel_rem: 1'b0};
      OP_DIVU:   ctrl = '{is_div: 1'b1, a_signed: 1'b0, b_signed: 1'b0, sel_high: 1'b0, sel_rem: 1'b0};
      OP_REM:    ctrl = '{is_div: 1'b1, a_signed: 1'b1, b_signed: 1'b1, sel_high: 1'b0, sel_rem: 1'b1};
      OP_REMU:   ctrl = '{is_div: 1'b1, a_signed: 1'b0, b_signed: 1'b0, sel_high: 1'b0, sel_rem: 1'b1};
      default:   ctrl = '0;
    endcase
    return ctrl;
  endfunction

endpackage

// File: design/mdu_mul.sv
`timescale 1ns/1ps

module mdu_mul #(
  parameter int WIDTH = 32
) (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_start,
  input  mdu_pkg::mdu_ctrl_t  i_ctrl,
  input  logic [WIDTH-1:0]    i_a,
  input  logic [WIDTH-1:0]    i_b,
  output logic                o_done,
  output logic [WIDTH-1:0]    o_result
);

  logic [WIDTH:0]     a_ext;
  logic [WIDTH:0]     b_ext;
  logic [WIDTH:0]     a_q;
  logic [WIDTH:0]     b_q;
  logic               sel_high_q;
  logic               v1_q;
  logic [2*WIDTH+1:0] prod;

  // One extra bit makes every operand mix a signed multiply
  assign a_ext = {i_ctrl.a_signed & i_a[WIDTH-1], i_a};
  assign b_ext = {i_ctrl.b_signed & i_b[WIDTH-1], i_b};

  assign prod = $signed(a_q) * $signed(b_q);

  // Two-deep valid shift
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      v1_q   <= 1'b0;
      o_done <= 1'b0;
    end else begin
      v1_q   <= i_start;
      o_done <= v1_q;
    end
  end

  // Stage 1 operands
  always_ff @(posedge i_clk) begin
    if (i_start) begin
      a_q        <= a_ext;
      b_q        <= b_ext;
      sel_high_q <= i_ctrl.sel_high;
    end
  end

  // Stage 2 product and half select
  always_ff @(posedge i_clk) begin
    if (v1_q) begin
      if (sel_high_q)
        o_result <= prod[2*WIDTH-1:WIDTH];
      else
        o_result <= prod[WIDTH-1:0];
    end
  end

endmodule

// File: design/mdu_div.sv
`timescale 1ns/1ps

module mdu_div #(
  parameter int WIDTH = 32
) (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_start,
  input  mdu_pkg::mdu_ctrl_t  i_ctrl,
  input  logic [WIDTH-1:0]    i_a,
  input  logic [WIDTH-1:0]    i_b,
  output logic                o_done,
  output logic [WIDTH-1:0]    o_result
);

  localparam int CW = $clog2(WIDTH + 1);
  localparam logic [WIDTH-1:0] MOST_NEG = {1'b1, {(WIDTH-1){1'b0}}};

  logic             a_neg;
  logic             b_neg;
  logic [WIDTH-1:0] a_mag;
  logic [WIDTH-1:0] b_mag;
  logic [WIDTH:0]   rem_sh;
  logic [WIDTH:0]   diff;
  logic [WIDTH-1:0] q_fix;
  logic [WIDTH-1:0] r_fix;

  logic             run_q;
  logic             fix_q;
  logic [CW-1:0]    cnt_q;
  logic [WIDTH-1:0] quo_q;  // Dividend shifts out as quotient shifts in
  logic [WIDTH-1:0] rem_q;
  logic [WIDTH-1:0] dsr_q;
  logic [WIDTH-1:0] dvd_q;  // Original dividend for special cases
  logic             q_neg_q;
  logic             r_neg_q;
  logic             zero_q;
  logic             ovf_q;
  logic             sel_rem_q;

  assign a_neg = i_ctrl.a_signed & i_a[WIDTH-1];
  assign b_neg = i_ctrl.b_signed & i_b[WIDTH-1];
  assign a_mag = a_neg ? -i_a : i_a;
  assign b_mag = b_neg ? -i_b : i_b;

  // Restoring step
  assign rem_sh = {rem_q, quo_q[WIDTH-1]};
  assign diff   = rem_sh - {1'b0, dsr_q};

  always_comb begin
    if (zero_q) begin
      q_fix = '1;
      r_fix = dvd_q;
    end else if (ovf_q) begin
      q_fix = dvd_q;
      r_fix = '0;
    end else begin
      q_fix = q_neg_q ? -quo_q : quo_q;
      r_fix = r_neg_q ? -rem_q : rem_q; // Remainder follows dividend sign
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      run_q  <= 1'b0;
      fix_q  <= 1'b0;
      o_done <= 1'b0;
      cnt_q  <= '0;
    end else begin
      fix_q  <= 1'b0;
      o_done <= fix_q;
      if (i_start) begin
        run_q <= 1'b1;
        cnt_q <= CW'(WIDTH);
      end else if (run_q) begin
        cnt_q <= cnt_q - 1'b1;
        if (cnt_q == CW'(1)) begin
          run_q <= 1'b0;
          fix_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      quo_q     <= a_mag;
      rem_q     <= '0;
      dsr_q     <= b_mag;
      dvd_q     <= i_a;
      q_neg_q   <= a_neg ^ b_neg;
      r_neg_q   <= a_neg;
      zero_q    <= ~|i_b;
      ovf_q     <= i_ctrl.a_signed & i_ctrl.b_signed & (i_a == MOST_NEG) & (&i_b);
      sel_rem_q <= i_ctrl.sel_rem;
    end else if (run_q) begin
      if (!diff[WIDTH]) begin
        rem_q <= diff[WIDTH-1:0];
        quo_q <= {quo_q[WIDTH-2:0], 1'b1};
      end else begin
        rem_q <= rem_sh[WIDTH-1:0];
        quo_q <= {quo_q[WIDTH-2:0], 1'b0};
      end
    end
  end

  // Sign fix and select
  always_ff @(posedge i_clk) begin
    if (fix_q)
      o_result <= sel_rem_q ? r_fix : q_fix;
  end

endmodule

// File: design/mdu_top.sv
`timescale 1ns/1ps

module mdu_top #(
  parameter int WIDTH = mdu_pkg::XLEN
) (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_mdu_valid,
  input  mdu_pkg::mdu_op_t  i_mdu_op,
  input  logic [WIDTH-1:0]  i_mdu_rs1,
  input  logic [WIDTH-1:0]  i_mdu_rs2,
  output logic              o_mdu_ready,
  output logic [WIDTH-1:0]  o_mdu_rd
);

  logic               busy_q;
  logic               start_q;
  mdu_pkg::mdu_ctrl_t ctrl_q;
  logic [WIDTH-1:0]   rs1_q;
  logic [WIDTH-1:0]   rs2_q;

  logic               accept;
  logic               mul_start;
  logic               div_start;
  logic               mul_done;
  logic               div_done;
  logic [WIDTH-1:0]   mul_result;
  logic [WIDTH-1:0]   div_result;

  assign accept    = i_mdu_valid & ~busy_q;
  assign mul_start = start_q & ~ctrl_q.is_div;
  assign div_start = start_q & ctrl_q.is_div;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy_q      <= 1'b0;
      start_q     <= 1'b0;
      o_mdu_ready <= 1'b0;
    end else begin
      start_q     <= accept;
      o_mdu_ready <= mul_done | div_done;
      if (accept)
        busy_q <= 1'b1;
      else if (mul_done | div_done)
        busy_q <= 1'b0; // Free on the edge that raises ready
    end
  end

  // Request capture with a single decode
  always_ff @(posedge i_clk) begin
    if (accept) begin
      rs1_q  <= i_mdu_rs1;
      rs2_q  <= i_mdu_rs2;
      ctrl_q <= mdu_pkg::decode_op(i_mdu_op);
    end
  end

  always_ff @(posedge i_clk) begin
    if (mul_done | div_done)
      o_mdu_rd <= mul_done ? mul_result : div_result;
  end

  mdu_mul #(.WIDTH(WIDTH)) mdu_mul_i (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_start  (mul_start),
    .i_ctrl   (ctrl_q),
    .i_a      (rs1_q),
    .i_b      (rs2_q),
    .o_done   (mul_done),
    .o_result (mul_result)
  );

  mdu_div #(.WIDTH(WIDTH)) mdu_div_i (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_start  (div_start),
    .i_ctrl   (ctrl_q),
    .i_a      (rs1_q),
    .i_b      (rs2_q),
    .o_done   (div_done),
    .o_result (div_result)
  );

endmodule

// File: tb/mdu_props.sv
`timescale 1ns/1ps

module mdu_props (
  input logic i_clk,
  input logic i_rst,
  input logic i_mdu_ready,
  input logic i_mul_start,
  input logic i_mul_done
);

  // Result strobe is one cycle wide
  a_ready_pulse: assert property (
    @(posedge i_clk) disable iff (i_rst) i_mdu_ready |=> !i_mdu_ready
  ) else $error("o_mdu_ready stayed high for two cycles");

  a_ready_in_reset: assert property (
    @(posedge i_clk) i_rst |=> !i_mdu_ready
  ) else $error("o_mdu_ready high during reset");

  // Two product stages
  a_mul_two_cycles: assert property (
    @(posedge i_clk) disable iff (i_rst) $past(i_mul_start, 2) |-> i_mul_done
  ) else $error("multiplier done pulse missing two cycles after start");

endmodule

bind mdu_top mdu_props mdu_props_i (
  .i_clk       (i_clk),
  .i_rst       (i_rst),
  .i_mdu_ready (o_mdu_ready),
  .i_mul_start (mul_start),
  .i_mul_done  (mul_done)
);

// File: tb/mdu_tb.sv
`timescale 1ns/1ps

module mdu_tb;

  localparam int XLEN       = mdu_pkg::XLEN;
  localparam int RST_CYCLES = 16;
  localparam int N_CORNER   = 5 * 5 * 8;
  localparam int N_RAND     = 96;
  localparam int N_SPECIAL  = 6;
  localparam int STORM_LEN  = 40;
  localparam int N_OPS      = N_CORNER + N_RAND + N_SPECIAL + 2 * STORM_LEN;
  localparam int TIMEOUT    = N_OPS * (XLEN + 4) + RST_CYCLES + N_OPS * 4 + 100;
  localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};
  localparam logic [XLEN-1:0] MOST_POS = {1'b0, {(XLEN-1){1'b1}}};

  logic             i_clk;
  logic             i_rst;
  logic             i_mdu_valid;
  mdu_pkg::mdu_op_t i_mdu_op;
  logic [XLEN-1:0]  i_mdu_rs1;
  logic [XLEN-1:0]  i_mdu_rs2;
  logic             o_mdu_ready;
  logic [XLEN-1:0]  o_mdu_rd;

  int               seed;
  int               cyc;
  bit               model_busy;  // Unit busy as seen by the busy rule
  logic [XLEN-1:0]  exp_q[$];
  int               due_q[$];
  logic [XLEN-1:0]  corners [5];

  mdu_top #(.WIDTH(XLEN)) mdu_top_i (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_mdu_valid (i_mdu_valid),
    .i_mdu_op    (i_mdu_op),
    .i_mdu_rs1   (i_mdu_rs1),
    .i_mdu_rs2   (i_mdu_rs2),
    .o_mdu_ready (o_mdu_ready),
    .o_mdu_rd    (o_mdu_rd)
  );

  always #2 i_clk = ~i_clk;

  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic expect_equal(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
    if (actual !== expected) begin
      $display("Mismatch %s: expected 0x%h actual 0x%h", name, expected, actual);
      abort_run();
    end
  endtask

  function automatic logic [XLEN-1:0] expected_rd(input mdu_pkg::mdu_op_t op,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
    mdu_pkg::mdu_ctrl_t ctrl;
    logic [63:0]        ax;
    logic [63:0]        bx;
    logic [63:0]        prod;
    logic [63:0]        quo;
    logic [63:0]        rem;
    ctrl = mdu_pkg::decode_op(op);
    ax = ctrl.a_signed ? {{(64-XLEN){a[XLEN-1]}}, a} : {{(64-XLEN){1'b0}}, a};
    bx = ctrl.b_signed ? {{(64-XLEN){b[XLEN-1]}}, b} : {{(64-XLEN){1'b0}}, b};
    prod = ax * bx;  // Exact in 64 bits for every sign mix
    if (b == '0) begin
      quo = '1;
      rem = ax;
    end else if (ctrl.a_signed && a == MOST_NEG && b == '1) begin
      quo = ax;  // Overflow keeps the dividend
      rem = '0;
    end else if (ctrl.a_signed) begin
      quo = $signed(ax) / $signed(bx);  // Toward zero
      rem = $signed(ax) % $signed(bx);  // Sign of dividend
    end else begin
      quo = ax / bx;
      rem = ax % bx;
    end
    if (!ctrl.is_div)
      return ctrl.sel_high ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];
    else
      return ctrl.sel_rem ? rem[XLEN-1:0] : quo[XLEN-1:0];
  endfunction

  // Edges from the accepting edge to the edge that raises ready
  function automatic int latency(input mdu_pkg::mdu_op_t op);
    mdu_pkg::mdu_ctrl_t ctrl;
    ctrl = mdu_pkg::decode_op(op);
    if (ctrl.is_div)
      return XLEN + 3;
    else
      return 3;
  endfunction

  task automatic wait_idle();
    while (exp_q.size() != 0)
      @(posedge i_clk);
  endtask

  task automatic run_op(input mdu_pkg::mdu_op_t op, input logic [XLEN-1:0] a,
                        input logic [XLEN-1:0] b);
    @(posedge i_clk);
    i_mdu_valid <= 1'b1;
    i_mdu_op    <= op;
    i_mdu_rs1   <= a;
    i_mdu_rs2   <= b;
    @(posedge i_clk);
    i_mdu_valid <= 1'b0;
    wait_idle();
  endtask

  // Valid held high every cycle so most strobes land while busy
  task automatic strobe_storm(input int n, input bit mul_only);
    logic [2:0] r;
    for (int i = 0; i < n; i++) begin
      r = 3'($random(seed));
      if (mul_only)
        r[2] = 1'b0;
      @(posedge i_clk);
      i_mdu_valid <= 1'b1;
      i_mdu_op    <= mdu_pkg::mdu_op_t'(r);
      i_mdu_rs1   <= $random(seed);
      i_mdu_rs2   <= $random(seed);
    end
    @(posedge i_clk);
    i_mdu_valid <= 1'b0;
    wait_idle();
  endtask

  always @(posedge i_clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT) begin
      $display("Timeout after %0d cycles with %0d results still outstanding",
               cyc, exp_q.size());
      abort_run();
    end
  end

  always @(negedge i_clk) begin : scoreboard
    logic [XLEN-1:0] exp_val;
    int              due;
    if (o_mdu_ready === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("Result pulse at cycle %0d with no request outstanding", cyc);
        abort_run();
      end else begin
        exp_val = exp_q.pop_front();
        due     = due_q.pop_front();
        expect_equal("o_mdu_rd", 64'(exp_val), 64'(o_mdu_rd));
        expect_equal("o_mdu_ready cycle", 64'(due), 64'(cyc));
        model_busy = 1'b0;  // Freed by the edge that raised ready
      end
    end
    // Inputs seen here are sampled at the next rising edge
    if (i_rst === 1'b0 && i_mdu_valid === 1'b1 && !model_busy) begin
      exp_q.push_back(expected_rd(i_mdu_op, i_mdu_rs1, i_mdu_rs2));
      due_q.push_back(cyc + 1 + latency(i_mdu_op));
      model_busy = 1'b1;
    end
  end

  initial begin
    logic [XLEN-1:0]  a;
    logic [XLEN-1:0]  b;
    logic [31:0]      r;
    mdu_pkg::mdu_op_t op;
    seed        = 32'h4630_3f50;
    cyc         = 0;
    model_busy  = 1'b0;
    i_clk       = 1'b0;
    i_rst       = 1'b1;
    i_mdu_valid = 1'b0;
    i_mdu_op    = mdu_pkg::OP_MUL;
    i_mdu_rs1   = '0;
    i_mdu_rs2   = '0;
    corners[0]  = '0;
    corners[1]  = XLEN'(1);
    corners[2]  = '1;
    corners[3]  = MOST_NEG;
    corners[4]  = MOST_POS;

    // Strobe inside reset must be ignored
    repeat (8) @(posedge i_clk);
    i_mdu_valid <= 1'b1;
    repeat (4) @(posedge i_clk);
    i_mdu_valid <= 1'b0;
    repeat (RST_CYCLES - 12) @(posedge i_clk);
    i_rst <= 1'b0;
    @(negedge i_clk);
    expect_equal("o_mdu_ready", 64'(0), 64'(o_mdu_ready));
    repeat (5) @(posedge i_clk);

    for (int o = 0; o < 8; o++)
      for (int i = 0; i < 5; i++)
        for (int j = 0; j < 5; j++)
          run_op(mdu_pkg::mdu_op_t'(3'(o)), corners[i], corners[j]);

    for (int i = 0; i < N_RAND; i++) begin
      op = mdu_pkg::mdu_op_t'(3'($random(seed)));
      a  = $random(seed);
      r  = $random(seed);
      b  = i[0] ? r : {{(XLEN-8){r[7]}}, r[7:0]};  // Short divisors too
      run_op(op, a, b);
    end

    // Zero divisor and signed overflow
    for (int o = 4; o < 8; o++)
      run_op(mdu_pkg::mdu_op_t'(3'(o)), $random(seed), '0);
    run_op(mdu_pkg::OP_DIV, MOST_NEG, '1);
    run_op(mdu_pkg::OP_REM, MOST_NEG, '1);

    strobe_storm(STORM_LEN, 1'b1);
    strobe_storm(STORM_LEN, 1'b0);

    // Late spurious pulses still reach the scoreboard here
    repeat (8) @(posedge i_clk);
    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: mdu.f
design/mdu_pkg.sv
design/mdu_mul.sv
design/mdu_div.sv
design/mdu_top.sv
tb/mdu_props.sv
tb/mdu_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module mdu_tb \
  -f mdu.f \
  -o mdu_sim

./obj_dir/mdu_sim
